/* Bender.yml */
package:
  name: snq_entry

sources:
  - files:
      - rtl/snq_pkg.sv
      - rtl/snq_entry_if.sv
      - rtl/snq_entry_store.sv
      - rtl/snq_tag_fsm.sv
      - rtl/snq_resp_encode.sv
      - rtl/snq_hit_compare.sv
      - rtl/snq_entry_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/snq_entry_tb.sv

/* compile.f */
+incdir+tests
rtl/snq_pkg.sv
rtl/snq_entry_if.sv
rtl/snq_entry_store.sv
rtl/snq_tag_fsm.sv
rtl/snq_resp_encode.sv
rtl/snq_hit_compare.sv
rtl/snq_entry_top.sv
tests/snq_entry_tb.sv

/* rtl/snq_entry_if.sv */
// captured entry state, driven only by the storage block
`timescale 1ns/1ps

interface snq_entry_if;

  logic                           vld;
  logic                           issued;
  snq_pkg::snq_line_addr_u        addr;
  snq_pkg::snq_type_e             snp_type;
  logic [snq_pkg::DEPD_WIDTH-1:0] depd;

  modport store (
    output vld,
    output issued,
    output addr,
    output snp_type,
    output depd
  );

  modport ctrl (input vld, input issued);

  modport encode (input snp_type);

  modport hit (input vld, input addr, input depd);

endinterface

/* rtl/snq_entry_store.sv */
// entry registers of a single snoop queue slot
// a new request is only created into an empty slot
`timescale 1ns/1ps

module snq_entry_store (
  input  logic                           snqctrlclk,
  input  logic                           cpurst_b,
  input  logic                           create,
  input  logic [snq_pkg::PA_WIDTH-1:0]   create_addr,
  input  snq_pkg::snq_type_e             create_type,
  input  logic [snq_pkg::DEPD_WIDTH-1:0] create_depd,
  input  logic [snq_pkg::DEPD_WIDTH-1:0] depd_remove,
  input  logic                           vb_start_wait,
  input  logic [snq_pkg::VB_NUM-1:0]     vb_wait_id,
  input  logic [snq_pkg::VB_NUM-1:0]     vb_wait_remove,
  input  logic                           pop,
  input  logic                           tag_issued,
  output logic                           depd_clear,
  output logic                           vb_wait_vld,
  output logic [snq_pkg::VB_NUM-1:0]     depd_vb_id,
  snq_entry_if.store                     ent
);

  logic [snq_pkg::VB_NUM-1:0] wait_vb;

  // ----------------------------------------------------------------------
  // valid and issued
  // ----------------------------------------------------------------------
  always_ff @(posedge snqctrlclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      ent.vld    <= 1'b0;
      ent.issued <= 1'b0;
    end
    else
    begin
      if (create)
        ent.vld <= 1'b1;
      else if (pop)
        ent.vld <= 1'b0;

      if (pop)
        ent.issued <= 1'b0;
      else if (tag_issued)
        ent.issued <= 1'b1;
    end
  end

  // request payload, 16-byte aligned line address
  always_ff @(posedge snqctrlclk)
  begin
    if (create)
    begin
      ent.addr.raw <= create_addr[snq_pkg::PA_WIDTH-1:4];
      ent.snp_type <= create_type;
    end
  end

  // ----------------------------------------------------------------------
  // issue dependencies, removed bit by bit
  // ----------------------------------------------------------------------
  always_ff @(posedge snqctrlclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ent.depd <= '0;
    else if (create)
      ent.depd <= create_depd;
    else
      ent.depd <= ent.depd & ~depd_remove;
  end

  assign depd_clear = ~|ent.depd;

  // evict deadlock avoidance needs the victim ids this entry waits on
  assign depd_vb_id = {snq_pkg::VB_NUM{ent.vld}} & ent.depd[snq_pkg::VB_NUM-1:0];

  // victim buffer data still in flight
  always_ff @(posedge snqctrlclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      wait_vb <= '0;
    else if (vb_start_wait)
      wait_vb <= vb_wait_id;
    else
      wait_vb <= wait_vb & ~vb_wait_remove;
  end

  assign vb_wait_vld = |wait_vb;

  a_create_empty: assert property (
    @(posedge snqctrlclk) disable iff (!cpurst_b)
    create |-> !ent.vld);

endmodule

/* rtl/snq_entry_top.sv */
// one snoop queue entry with plain ports, all registers on snqctrlclk
// cr_resp and way hold stale data until the first tag response
`timescale 1ns/1ps

module snq_entry_top (
  input  logic                                snqctrlclk,
  input  logic                                cpurst_b,
  input  logic                                create,
  input  logic [snq_pkg::PA_WIDTH-1:0]        create_addr,
  input  snq_pkg::snq_type_e                  create_type,
  input  logic [snq_pkg::DEPD_WIDTH-1:0]      create_depd,
  input  logic [snq_pkg::DEPD_WIDTH-1:0]      depd_remove,
  input  logic                                vb_start_wait,
  input  logic [snq_pkg::VB_NUM-1:0]          vb_wait_id,
  input  logic [snq_pkg::VB_NUM-1:0]          vb_wait_remove,
  input  logic                                tag_start,
  input  logic                                tag_grnt,
  input  logic                                tag_resp_create,
  input  logic                                tag_resp_valid,
  input  logic                                tag_resp_dirty,
  input  logic                                tag_resp_share,
  input  logic                                tag_resp_way,
  input  logic                                ecc_err,
  input  logic                                oldest,
  input  logic                                snpdt_grnt,
  input  logic                                snpdt_cmplt,
  input  logic                                cr_resp_accept,
  input  logic [snq_pkg::PA_WIDTH-1:0]        wmb_write_addr,
  input  logic [snq_pkg::WMB_NUM-1:0]         wmb_write_ptr,
  input  logic [snq_pkg::PA_WIDTH-1:0]        wmb_read_addr,
  input  logic [snq_pkg::PA_WIDTH-7:0]        lfb_vb_addr,
  output logic                                vld,
  output logic                                rd_tag_rdy,
  output logic                                issued,
  output logic [snq_pkg::LINE_ADDR_WIDTH-1:0] entry_addr,
  output logic                                snpdt_start,
  output logic                                need_read_data,
  output logic                                need_chg_tag,
  output logic                                need_chg_tag_s,
  output logic                                need_chg_tag_i,
  output logic                                tag_req_for_inv,
  output logic                                read_once,
  output logic                                way,
  output logic                                cr_resp_valid,
  output logic [4:0]                          cr_resp,
  output logic [snq_pkg::VB_NUM-1:0]          depd_vb_id,
  output logic                                wmb_write_hit,
  output logic                                wmb_read_hit,
  output logic                                lfb_vb_hit
);

  logic depd_clear;
  logic vb_wait_vld;
  logic pop;
  logic tag_issued;
  logic need_snpdt;

  snq_entry_if ent_if ();

  assign vld        = ent_if.vld;
  assign issued     = ent_if.issued;
  assign entry_addr = ent_if.addr.raw;

  // ----------------------------------------------------------------------
  // storage and control
  // ----------------------------------------------------------------------
  snq_entry_store u_store (
    .snqctrlclk     (snqctrlclk),
    .cpurst_b       (cpurst_b),
    .create         (create),
    .create_addr    (create_addr),
    .create_type    (create_type),
    .create_depd    (create_depd),
    .depd_remove    (depd_remove),
    .vb_start_wait  (vb_start_wait),
    .vb_wait_id     (vb_wait_id),
    .vb_wait_remove (vb_wait_remove),
    .pop            (pop),
    .tag_issued     (tag_issued),
    .depd_clear     (depd_clear),
    .vb_wait_vld    (vb_wait_vld),
    .depd_vb_id     (depd_vb_id),
    .ent            (ent_if)
  );

  snq_tag_fsm u_fsm (
    .snqctrlclk      (snqctrlclk),
    .cpurst_b        (cpurst_b),
    .ent             (ent_if),
    .tag_start       (tag_start),
    .tag_grnt        (tag_grnt),
    .tag_resp_create (tag_resp_create),
    .need_snpdt      (need_snpdt),
    .oldest          (oldest),
    .snpdt_grnt      (snpdt_grnt),
    .snpdt_cmplt     (snpdt_cmplt),
    .cr_resp_accept  (cr_resp_accept),
    .depd_clear      (depd_clear),
    .vb_wait_vld     (vb_wait_vld),
    .rd_tag_rdy      (rd_tag_rdy),
    .tag_issued      (tag_issued),
    .snpdt_start     (snpdt_start),
    .cr_resp_valid   (cr_resp_valid),
    .pop             (pop)
  );

  // ----------------------------------------------------------------------
  // response and hit detection
  // ----------------------------------------------------------------------
  snq_resp_encode u_encode (
    .snqctrlclk      (snqctrlclk),
    .cpurst_b        (cpurst_b),
    .ent             (ent_if),
    .tag_resp_create (tag_resp_create),
    .tag_resp_valid  (tag_resp_valid),
    .tag_resp_dirty  (tag_resp_dirty),
    .tag_resp_share  (tag_resp_share),
    .tag_resp_way    (tag_resp_way),
    .ecc_err         (ecc_err),
    .cr_resp         (cr_resp),
    .way             (way),
    .need_read_data  (need_read_data),
    .need_chg_tag    (need_chg_tag),
    .need_chg_tag_s  (need_chg_tag_s),
    .need_chg_tag_i  (need_chg_tag_i),
    .tag_req_for_inv (tag_req_for_inv),
    .read_once       (read_once),
    .need_snpdt      (need_snpdt)
  );

  snq_hit_compare u_hit (
    .ent            (ent_if),
    .wmb_write_addr (wmb_write_addr),
    .wmb_write_ptr  (wmb_write_ptr),
    .wmb_read_addr  (wmb_read_addr),
    .lfb_vb_addr    (lfb_vb_addr),
    .wmb_write_hit  (wmb_write_hit),
    .wmb_read_hit   (wmb_read_hit),
    .lfb_vb_hit     (lfb_vb_hit)
  );

endmodule

/* rtl/snq_hit_compare.sv */
// index match of the entry against other requesters, index is PA 13:6
`timescale 1ns/1ps

module snq_hit_compare (
  snq_entry_if.hit                     ent,
  input  logic [snq_pkg::PA_WIDTH-1:0] wmb_write_addr,
  input  logic [snq_pkg::WMB_NUM-1:0]  wmb_write_ptr,
  input  logic [snq_pkg::PA_WIDTH-1:0] wmb_read_addr,
  input  logic [snq_pkg::PA_WIDTH-7:0] lfb_vb_addr,
  output logic                         wmb_write_hit,
  output logic                         wmb_read_hit,
  output logic                         lfb_vb_hit
);

  logic [snq_pkg::INDEX_WIDTH-1:0] idx;
  logic                            wmb_free_ptr;

  assign idx = ent.addr.f.index;

  // a write this entry already waits on does not count
  assign wmb_free_ptr = |(wmb_write_ptr & ~ent.depd[snq_pkg::DEPD_WIDTH-1:snq_pkg::VB_NUM]);

  assign wmb_write_hit = ent.vld & (idx == wmb_write_addr[13:6]) & wmb_free_ptr;
  assign wmb_read_hit  = ent.vld & (idx == wmb_read_addr[13:6]);

  // lfb and vb address already starts at bit 6
  assign lfb_vb_hit = ent.vld & (idx == lfb_vb_addr[snq_pkg::INDEX_WIDTH-1:0]);

endmodule

/* rtl/snq_pkg.sv */
// shared types for one snoop queue entry
// physical address fixed at 40 bits, entry keeps bits 39:4 only
package snq_pkg;

  localparam int PA_WIDTH        = 40;
  localparam int LINE_ADDR_WIDTH = PA_WIDTH - 4;
  localparam int INDEX_WIDTH     = 8;
  localparam int VB_NUM          = 2;
  localparam int WMB_NUM         = 8;
  // low bits victim buffer, high bits write merge buffer
  localparam int DEPD_WIDTH      = VB_NUM + WMB_NUM;

  // ----------------------------------------------------------------------
  // stored line address, raw or split into cache fields
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [LINE_ADDR_WIDTH-INDEX_WIDTH-3:0] tag;
    logic [INDEX_WIDTH-1:0]                 index;
    logic [1:0]                             offset;
  } snq_line_fields_t;

  typedef union packed {
    logic [LINE_ADDR_WIDTH-1:0] raw;
    snq_line_fields_t           f;
  } snq_line_addr_u;

  // snoop request types
  typedef enum logic [3:0] {
    READ_ONCE     = 4'b0000,
    READ_SHARED   = 4'b0001,
    READ_UNIQUE   = 4'b0111,
    CLEAN_SHARED  = 4'b1000,
    CLEAN_INVALID = 4'b1001,
    MAKE_INVALID  = 4'b1101
  } snq_type_e;

  // one-hot, idle is all zero
  typedef enum logic [4:0] {
    IDLE             = 5'b00000,
    WAIT_DATA_BUFFER = 5'b00001,
    WAIT_RESP        = 5'b00010,
    SDT_REQ          = 5'b00100,
    WAIT_SDT_CMPLT   = 5'b01000,
    WAIT_POP         = 5'b10000
  } snq_state_e;

  // coherence response word
  typedef struct packed {
    logic was_unique;
    logic is_shared;
    logic pass_dirty;
    logic error;
    logic data_transfer;
  } snq_cr_resp_t;

endpackage

/* rtl/snq_resp_encode.sv */
// coherence response from the tag lookup, held until the entry pops
// only M lines transfer data, the next cache level is inclusive
`timescale 1ns/1ps

module snq_resp_encode (
  input  logic                  snqctrlclk,
  input  logic                  cpurst_b,
  snq_entry_if.encode           ent,
  input  logic                  tag_resp_create,
  input  logic                  tag_resp_valid,
  input  logic                  tag_resp_dirty,
  input  logic                  tag_resp_share,
  input  logic                  tag_resp_way,
  input  logic                  ecc_err,
  output snq_pkg::snq_cr_resp_t cr_resp,
  output logic                  way,
  output logic                  need_read_data,
  output logic                  need_chg_tag,
  output logic                  need_chg_tag_s,
  output logic                  need_chg_tag_i,
  output logic                  tag_req_for_inv,
  output logic                  read_once,
  output logic                  need_snpdt
);

  logic                  is_ro;
  logic                  is_rs;
  logic                  is_ru;
  logic                  is_cs;
  logic                  is_ci;
  logic                  is_mi;
  logic                  m_line;
  logic                  chg_m;
  logic                  chg_s;
  logic                  chg_i;
  snq_pkg::snq_cr_resp_t resp_nxt;

  assign is_ro = ent.snp_type == snq_pkg::READ_ONCE;
  assign is_rs = ent.snp_type == snq_pkg::READ_SHARED;
  assign is_ru = ent.snp_type == snq_pkg::READ_UNIQUE;
  assign is_cs = ent.snp_type == snq_pkg::CLEAN_SHARED;
  assign is_ci = ent.snp_type == snq_pkg::CLEAN_INVALID;
  assign is_mi = ent.snp_type == snq_pkg::MAKE_INVALID;

  assign m_line = tag_resp_valid & tag_resp_dirty;

  // ----------------------------------------------------------------------
  // response word
  // ----------------------------------------------------------------------
  assign resp_nxt.was_unique    = 1'b0;
  assign resp_nxt.is_shared     = tag_resp_valid & (is_ro | is_rs | is_cs);
  assign resp_nxt.pass_dirty    = m_line & (is_rs | is_ru | is_cs | is_ci);
  assign resp_nxt.error         = ecc_err;
  assign resp_nxt.data_transfer = m_line & (is_ro | is_rs | is_ru | is_cs | is_ci);

  // tag state changes, M always leaves M
  assign chg_m = m_line & is_cs;
  assign chg_s = tag_resp_valid & ~tag_resp_share & (is_cs | is_rs);
  assign chg_i = tag_resp_valid & (is_ru | is_ci | is_mi);

  // decides the FSM branch in the response cycle
  assign need_snpdt = resp_nxt.data_transfer | chg_m | chg_s | chg_i;

  always_ff @(posedge snqctrlclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      need_read_data <= 1'b0;
      need_chg_tag   <= 1'b0;
      need_chg_tag_s <= 1'b0;
      need_chg_tag_i <= 1'b0;
    end
    else if (tag_resp_create)
    begin
      need_read_data <= resp_nxt.data_transfer;
      need_chg_tag   <= chg_m | chg_s | chg_i;
      need_chg_tag_s <= chg_s;
      need_chg_tag_i <= chg_i;
    end
  end

  always_ff @(posedge snqctrlclk)
  begin
    if (tag_resp_create)
    begin
      cr_resp <= resp_nxt;
      way     <= tag_resp_way;
    end
  end

  assign tag_req_for_inv = is_ru | is_ci | is_mi;
  assign read_once       = is_ro;

endmodule

/* rtl/snq_tag_fsm.sv */
// snoop tag sequencing for one entry, one request in flight
// oldest comes from the queue arbiter and gates data and response phases
`timescale 1ns/1ps

module snq_tag_fsm (
  input  logic       snqctrlclk,
  input  logic       cpurst_b,
  snq_entry_if.ctrl  ent,
  input  logic       tag_start,
  input  logic       tag_grnt,
  input  logic       tag_resp_create,
  input  logic       need_snpdt,
  input  logic       oldest,
  input  logic       snpdt_grnt,
  input  logic       snpdt_cmplt,
  input  logic       cr_resp_accept,
  input  logic       depd_clear,
  input  logic       vb_wait_vld,
  output logic       rd_tag_rdy,
  output logic       tag_issued,
  output logic       snpdt_start,
  output logic       cr_resp_valid,
  output logic       pop
);

  snq_pkg::snq_state_e state;
  snq_pkg::snq_state_e state_nxt;

  assign rd_tag_rdy = ent.vld & depd_clear & ~ent.issued;

  always_ff @(posedge snqctrlclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      state <= snq_pkg::IDLE;
    else
      state <= state_nxt;
  end

  // ----------------------------------------------------------------------
  // next state
  // ----------------------------------------------------------------------
  always_comb
  begin
    state_nxt = state;
    case (state)
      snq_pkg::IDLE:
      begin
        if (tag_issued)
          state_nxt = snq_pkg::WAIT_RESP;
      end
      snq_pkg::WAIT_RESP:
      begin
        // read data or tag change first, else straight to pop
        if (tag_resp_create)
        begin
          if (need_snpdt)
            state_nxt = snq_pkg::SDT_REQ;
          else if (vb_wait_vld)
            state_nxt = snq_pkg::WAIT_DATA_BUFFER;
          else
            state_nxt = snq_pkg::WAIT_POP;
        end
      end
      snq_pkg::SDT_REQ:
      begin
        if (oldest && snpdt_grnt)
          state_nxt = snq_pkg::WAIT_SDT_CMPLT;
      end
      snq_pkg::WAIT_SDT_CMPLT:
      begin
        if (snpdt_cmplt)
          state_nxt = vb_wait_vld ? snq_pkg::WAIT_DATA_BUFFER : snq_pkg::WAIT_POP;
      end
      snq_pkg::WAIT_DATA_BUFFER:
      begin
        // evict this entry depends on must drain first
        if (!vb_wait_vld)
          state_nxt = snq_pkg::WAIT_POP;
      end
      snq_pkg::WAIT_POP:
      begin
        if (pop)
          state_nxt = snq_pkg::IDLE;
      end
      default:
        state_nxt = snq_pkg::IDLE;
    endcase
  end

  // ----------------------------------------------------------------------
  // handshake outputs
  // ----------------------------------------------------------------------
  assign tag_issued    = tag_start & tag_grnt & (state == snq_pkg::IDLE);
  assign snpdt_start   = oldest & (state == snq_pkg::SDT_REQ);
  assign cr_resp_valid = oldest & (state == snq_pkg::WAIT_POP);
  assign pop           = cr_resp_valid & cr_resp_accept;

  a_state_onehot: assert property (
    @(posedge snqctrlclk) disable iff (!cpurst_b)
    $onehot0(state));

  // tag arbiter only selects entries that reported ready
  a_start_when_rdy: assert property (
    @(posedge snqctrlclk) disable iff (!cpurst_b)
    tag_start |-> rd_tag_rdy);

endmodule

/* tests/snq_entry_tasks.svh */
// directed tests, included inside the testbench module
// every test starts and ends on a falling edge with the entry empty
`ifndef SNQ_ENTRY_TASKS_SVH
`define SNQ_ENTRY_TASKS_SVH

function automatic snq_pkg::snq_type_e type_at(input int i);
  case (i)
    0:       return snq_pkg::READ_ONCE;
    1:       return snq_pkg::READ_SHARED;
    2:       return snq_pkg::READ_UNIQUE;
    3:       return snq_pkg::CLEAN_SHARED;
    4:       return snq_pkg::CLEAN_INVALID;
    default: return snq_pkg::MAKE_INVALID;
  endcase
endfunction

// {was_unique, is_shared, pass_dirty, error, data_transfer}
function automatic logic [4:0] expect_resp(input snq_pkg::snq_type_e t, input logic v,
                                           input logic d, input logic e);
  logic [2:0] allow;
  logic       m;
  m = v & d;
  // per type: data transfer, pass dirty, shared
  case (t)
    snq_pkg::READ_ONCE:     allow = 3'b101;
    snq_pkg::READ_SHARED:   allow = 3'b111;
    snq_pkg::READ_UNIQUE:   allow = 3'b110;
    snq_pkg::CLEAN_SHARED:  allow = 3'b111;
    snq_pkg::CLEAN_INVALID: allow = 3'b110;
    default:                allow = 3'b000;
  endcase
  return {1'b0, allow[0] & v, allow[1] & m, e, allow[2] & m};
endfunction

// {need_read_data, need_chg_tag, need_chg_tag_s, need_chg_tag_i}
function automatic logic [3:0] expect_flags(input snq_pkg::snq_type_e t, input logic v,
                                            input logic d, input logic s);
  logic rd;
  logic to_s;
  logic to_i;
  logic from_m;
  rd     = |(expect_resp(t, v, d, 1'b0) & 5'b00001);
  from_m = v & d & (t == snq_pkg::CLEAN_SHARED);
  to_s   = v & ~s & (t == snq_pkg::CLEAN_SHARED || t == snq_pkg::READ_SHARED);
  to_i   = v & (t == snq_pkg::READ_UNIQUE || t == snq_pkg::CLEAN_INVALID ||
                t == snq_pkg::MAKE_INVALID);
  return {rd, from_m | to_s | to_i, to_s, to_i};
endfunction

task automatic reset_values();
  check_val("vld", vld, 0);
  check_val("rd_tag_rdy", rd_tag_rdy, 0);
  check_val("issued", issued, 0);
  check_val("snpdt_start", snpdt_start, 0);
  check_val("cr_resp_valid", cr_resp_valid, 0);
  check_val("need flags", {need_read_data, need_chg_tag, need_chg_tag_s, need_chg_tag_i}, 0);
endtask

task automatic dependency_release();
  logic [63:0] r;
  logic [39:0] addr;
  logic [9:0]  depd;
  random_bits(40, r);
  addr = r[39:0];
  random_bits(10, r);
  depd = r[9:0];
  if (depd == '0)
    depd = 10'h001;
  create_entry(addr, snq_pkg::READ_ONCE, depd);
  check_val("entry_addr", entry_addr, addr[39:4]);
  check_val("depd_vb_id", depd_vb_id, depd[1:0]);
  // remove one bit per cycle, lowest first
  for (int b = 0; b < 10; b++)
  begin
    if (depd[b])
    begin
      check_val("rd_tag_rdy", rd_tag_rdy, 0);
      depd_remove = 10'b1 << b;
      @(negedge snqctrlclk);
      depd_remove = '0;
      depd[b]     = 1'b0;
      check_val("depd_vb_id", depd_vb_id, depd[1:0]);
    end
  end
  check_val("rd_tag_rdy", rd_tag_rdy, 1);
  issue_tag();
  send_tag_resp(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  drain_entry(1'b0);
endtask

task automatic response_table();
  logic [63:0]        r;
  logic [4:0]         resp;
  logic [3:0]         flags;
  logic               sdt;
  snq_pkg::snq_type_e t;
  for (int ti = 0; ti < 6; ti++)
  begin
    for (int c = 0; c < 8; c++)
    begin
      t = type_at(ti);
      random_bits(42, r);
      create_entry(r[39:0], t, '0);
      check_val("tag_req_for_inv", tag_req_for_inv,
                t == snq_pkg::READ_UNIQUE || t == snq_pkg::CLEAN_INVALID ||
                t == snq_pkg::MAKE_INVALID);
      check_val("read_once", read_once, t == snq_pkg::READ_ONCE);
      issue_tag();
      // c picks valid, dirty and share
      send_tag_resp(c[2], c[1], c[0], r[40], r[41]);
      resp  = expect_resp(t, c[2], c[1], r[41]);
      flags = expect_flags(t, c[2], c[1], c[0]);
      sdt   = |flags;
      check_val("cr_resp", cr_resp, resp);
      check_val("need flags", {need_read_data, need_chg_tag, need_chg_tag_s, need_chg_tag_i},
                flags);
      check_val("way", way, r[40]);
      oldest = 1'b1;
      @(negedge snqctrlclk);
      check_val("snpdt_start", snpdt_start, sdt);
      check_val("cr_resp_valid", cr_resp_valid, !sdt);
      drain_entry(sdt);
    end
  end
endtask

task automatic full_snoop_flow();
  logic [63:0] r;
  random_bits(40, r);
  create_entry(r[39:0], snq_pkg::READ_SHARED, '0);
  issue_tag();
  send_tag_resp(1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
  // shared, pass dirty and data transfer
  check_val("cr_resp", cr_resp, 5'b01101);
  repeat (3)
  begin
    @(negedge snqctrlclk);
    check_val("snpdt_start", snpdt_start, 0);
  end
  oldest = 1'b1;
  wait_snpdt_start();
  snpdt_grnt = 1'b1;
  @(negedge snqctrlclk);
  check_val("snpdt_start", snpdt_start, 0);
  snpdt_grnt  = 1'b0;
  oldest      = 1'b0;
  snpdt_cmplt = 1'b1;
  @(negedge snqctrlclk);
  snpdt_cmplt = 1'b0;
  repeat (3)
  begin
    @(negedge snqctrlclk);
    check_val("cr_resp_valid", cr_resp_valid, 0);
  end
  drain_entry(1'b0);
endtask

task automatic victim_wait_flow();
  logic [63:0] r;
  random_bits(40, r);
  create_entry(r[39:0], snq_pkg::CLEAN_INVALID, '0);
  vb_start_wait = 1'b1;
  vb_wait_id    = 2'b10;
  @(negedge snqctrlclk);
  vb_start_wait = 1'b0;
  vb_wait_id    = '0;
  issue_tag();
  send_tag_resp(1'b1, 1'b1, 1'b0, 1'b1, 1'b0);
  oldest = 1'b1;
  wait_snpdt_start();
  snpdt_grnt = 1'b1;
  @(negedge snqctrlclk);
  snpdt_grnt  = 1'b0;
  snpdt_cmplt = 1'b1;
  @(negedge snqctrlclk);
  snpdt_cmplt = 1'b0;
  // evict still in flight
  repeat (3)
  begin
    @(negedge snqctrlclk);
    check_val("cr_resp_valid", cr_resp_valid, 0);
  end
  vb_wait_remove = 2'b10;
  @(negedge snqctrlclk);
  vb_wait_remove = '0;
  drain_entry(1'b0);
endtask

task automatic index_hits();
  logic [63:0] r;
  logic [39:0] addr;
  logic [7:0]  idx;
  logic [7:0]  flip;
  int          p;
  random_bits(40, r);
  addr = r[39:0];
  idx  = addr[13:6];
  random_bits(11, r);
  p    = r[2:0];
  flip = r[10:3] | 8'h01;
  create_entry(addr, snq_pkg::READ_ONCE, 10'b1 << (p + 2));
  random_bits(40, r);
  wmb_read_addr  = {r[39:14], idx, r[5:0]};
  lfb_vb_addr    = {r[33:8], idx};
  wmb_write_addr = {r[39:14], idx ^ flip, r[5:0]};
  wmb_write_ptr  = 8'b1 << ((p + 1) % 8);
  @(negedge snqctrlclk);
  check_val("wmb_read_hit", wmb_read_hit, 1);
  check_val("lfb_vb_hit", lfb_vb_hit, 1);
  check_val("wmb_write_hit", wmb_write_hit, 0);
  wmb_write_addr = {r[39:14], idx, r[5:0]};
  @(negedge snqctrlclk);
  check_val("wmb_write_hit", wmb_write_hit, 1);
  // pointed entry is already a dependency
  wmb_write_ptr = 8'b1 << p;
  @(negedge snqctrlclk);
  check_val("wmb_write_hit", wmb_write_hit, 0);
  wmb_read_addr = {r[39:14], idx ^ flip, r[5:0]};
  lfb_vb_addr   = {r[33:8], idx ^ flip};
  @(negedge snqctrlclk);
  check_val("wmb_read_hit", wmb_read_hit, 0);
  check_val("lfb_vb_hit", lfb_vb_hit, 0);
  depd_remove = '1;
  @(negedge snqctrlclk);
  depd_remove = '0;
  issue_tag();
  send_tag_resp(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  drain_entry(1'b0);
  // empty entry never hits
  wmb_read_addr = {r[39:14], idx, r[5:0]};
  @(negedge snqctrlclk);
  check_val("wmb_read_hit", wmb_read_hit, 0);
endtask

`endif

/* tests/snq_entry_tb.sv */
// testbench for one snoop queue entry, inputs change on the falling edge
// outputs are sampled on the falling edge before new inputs are driven
`timescale 1ns/1ps

module snq_entry_tb;

  localparam int WAIT_LIMIT = 50;

  logic                                snqctrlclk;
  logic                                cpurst_b;
  logic                                create;
  logic [snq_pkg::PA_WIDTH-1:0]        create_addr;
  snq_pkg::snq_type_e                  create_type;
  logic [snq_pkg::DEPD_WIDTH-1:0]      create_depd;
  logic [snq_pkg::DEPD_WIDTH-1:0]      depd_remove;
  logic                                vb_start_wait;
  logic [snq_pkg::VB_NUM-1:0]          vb_wait_id;
  logic [snq_pkg::VB_NUM-1:0]          vb_wait_remove;
  logic                                tag_start;
  logic                                tag_grnt;
  logic                                tag_resp_create;
  logic                                tag_resp_valid;
  logic                                tag_resp_dirty;
  logic                                tag_resp_share;
  logic                                tag_resp_way;
  logic                                ecc_err;
  logic                                oldest;
  logic                                snpdt_grnt;
  logic                                snpdt_cmplt;
  logic                                cr_resp_accept;
  logic [snq_pkg::PA_WIDTH-1:0]        wmb_write_addr;
  logic [snq_pkg::WMB_NUM-1:0]         wmb_write_ptr;
  logic [snq_pkg::PA_WIDTH-1:0]        wmb_read_addr;
  logic [snq_pkg::PA_WIDTH-7:0]        lfb_vb_addr;
  logic                                vld;
  logic                                rd_tag_rdy;
  logic                                issued;
  logic [snq_pkg::LINE_ADDR_WIDTH-1:0] entry_addr;
  logic                                snpdt_start;
  logic                                need_read_data;
  logic                                need_chg_tag;
  logic                                need_chg_tag_s;
  logic                                need_chg_tag_i;
  logic                                tag_req_for_inv;
  logic                                read_once;
  logic                                way;
  logic                                cr_resp_valid;
  logic [4:0]                          cr_resp;
  logic [snq_pkg::VB_NUM-1:0]          depd_vb_id;
  logic                                wmb_write_hit;
  logic                                wmb_read_hit;
  logic                                lfb_vb_hit;
  logic [15:0]                         lfsr_state;

  always #4 snqctrlclk = ~snqctrlclk;

  snq_entry_top UUT (.*);

  // ----------------------------------------------------------------------
  // random source, x^16 + x^14 + x^13 + x^11 + 1
  // ----------------------------------------------------------------------
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  // one lfsr step per bit taken
  task automatic random_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[62:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // ----------------------------------------------------------------------
  // failure reporting
  // ----------------------------------------------------------------------
  task automatic abort_run();
    $display("TEST FAIL");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("[ERROR] %0t ns %s got %0h expected %0h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("waited %0d cycles and %s never went high", WAIT_LIMIT, what);
    abort_run();
  endtask

  // each wait moves at least one falling edge before looking
  task automatic wait_tag_ready();
    int n;
    n = 0;
    @(negedge snqctrlclk);
    while (rd_tag_rdy !== 1'b1)
    begin
      n++;
      if (n > WAIT_LIMIT)
        timeout_fail("rd_tag_rdy");
      @(negedge snqctrlclk);
    end
  endtask

  task automatic wait_snpdt_start();
    int n;
    n = 0;
    @(negedge snqctrlclk);
    while (snpdt_start !== 1'b1)
    begin
      n++;
      if (n > WAIT_LIMIT)
        timeout_fail("snpdt_start");
      @(negedge snqctrlclk);
    end
  endtask

  task automatic wait_resp_valid();
    int n;
    n = 0;
    @(negedge snqctrlclk);
    while (cr_resp_valid !== 1'b1)
    begin
      n++;
      if (n > WAIT_LIMIT)
        timeout_fail("cr_resp_valid");
      @(negedge snqctrlclk);
    end
  endtask

  // ----------------------------------------------------------------------
  // entry handshakes, called and returning on a falling edge
  // ----------------------------------------------------------------------
  task automatic create_entry(input logic [39:0] addr, input snq_pkg::snq_type_e t,
                              input logic [9:0] depd);
    create      = 1'b1;
    create_addr = addr;
    create_type = t;
    create_depd = depd;
    @(negedge snqctrlclk);
    create = 1'b0;
    check_val("vld", vld, 1);
    check_val("issued", issued, 0);
  endtask

  task automatic issue_tag();
    wait_tag_ready();
    tag_start = 1'b1;
    tag_grnt  = 1'b1;
    @(negedge snqctrlclk);
    tag_start = 1'b0;
    tag_grnt  = 1'b0;
    check_val("issued", issued, 1);
    check_val("rd_tag_rdy", rd_tag_rdy, 0);
  endtask

  task automatic send_tag_resp(input logic v, input logic d, input logic s,
                               input logic w, input logic e);
    tag_resp_create = 1'b1;
    tag_resp_valid  = v;
    tag_resp_dirty  = d;
    tag_resp_share  = s;
    tag_resp_way    = w;
    ecc_err         = e;
    @(negedge snqctrlclk);
    tag_resp_create = 1'b0;
  endtask

  // data phase when needed, then response accept and pop
  task automatic drain_entry(input logic with_sdt);
    oldest = 1'b1;
    if (with_sdt)
    begin
      wait_snpdt_start();
      snpdt_grnt = 1'b1;
      @(negedge snqctrlclk);
      snpdt_grnt = 1'b0;
      check_val("snpdt_start", snpdt_start, 0);
      snpdt_cmplt = 1'b1;
      @(negedge snqctrlclk);
      snpdt_cmplt = 1'b0;
    end
    wait_resp_valid();
    cr_resp_accept = 1'b1;
    @(negedge snqctrlclk);
    check_val("vld", vld, 0);
    check_val("issued", issued, 0);
    check_val("cr_resp_valid", cr_resp_valid, 0);
    cr_resp_accept = 1'b0;
    oldest         = 1'b0;
  endtask

  `include "snq_entry_tasks.svh"

  initial
  begin
    snqctrlclk      = 1'b0;
    cpurst_b        = 1'b0;
    create          = 1'b0;
    create_addr     = '0;
    create_type     = snq_pkg::READ_ONCE;
    create_depd     = '0;
    depd_remove     = '0;
    vb_start_wait   = 1'b0;
    vb_wait_id      = '0;
    vb_wait_remove  = '0;
    tag_start       = 1'b0;
    tag_grnt        = 1'b0;
    tag_resp_create = 1'b0;
    tag_resp_valid  = 1'b0;
    tag_resp_dirty  = 1'b0;
    tag_resp_share  = 1'b0;
    tag_resp_way    = 1'b0;
    ecc_err         = 1'b0;
    oldest          = 1'b0;
    snpdt_grnt      = 1'b0;
    snpdt_cmplt     = 1'b0;
    cr_resp_accept  = 1'b0;
    wmb_write_addr  = '0;
    wmb_write_ptr   = '0;
    wmb_read_addr   = '0;
    lfb_vb_addr     = '0;
    lfsr_state      = 16'd83;
    repeat (2) @(posedge snqctrlclk);
    @(negedge snqctrlclk);
    cpurst_b = 1'b1;
    @(negedge snqctrlclk);
    reset_values();
    dependency_release();
    response_table();
    full_snoop_flow();
    victim_wait_flow();
    index_hits();
    $display("TEST PASS");
    $finish;
  end

endmodule
